//--- list.f
src/tcu_pkg.sv
src/tcu_meta_fifo.sv
src/tcu_fedp.sv
src/tcu_core.sv
tb/tcu_checker.sv
tb/tb_tcu.sv

//--- run.sh
#!/bin/sh
# Build and run the tensor core testbench with Verilator
rm -f sim.log
verilator --binary --assert --top-module tb_tcu -f list.f -o tb_tcu_sim > build.log 2>&1 \
    && ./obj_dir/tb_tcu_sim > sim.log 2>&1
grep -q "Simulation finished: PASS" sim.log \
    && echo "Result: pass" \
    || { echo "Result: fail, see build.log and sim.log"; exit 1; }

//--- tb/tb_tcu.sv
// Tensor core testbench
`timescale 1ns/1ps

module tb_tcu;
    localparam int TC_M         = 2;
    localparam int TC_N         = 2;
    localparam int TC_K         = 4;
    localparam int A_SUB_BLOCKS = 2;
    localparam int B_SUB_BLOCKS = 2;
    localparam int XLEN         = tcu_pkg::XLEN;
    localparam int A_LANES      = A_SUB_BLOCKS * TC_M * TC_K;
    localparam int B_LANES      = B_SUB_BLOCKS * TC_N * TC_K;
    localparam int C_LANES      = TC_M * TC_N;
    localparam int NUM_REQ      = 300;
    localparam int MAX_CYCLES   = NUM_REQ * 20 + 200;

    logic                        clk;
    logic                        reset;
    logic                        execute_valid;
    logic                        execute_ready;
    logic [tcu_pkg::TAG_W-1:0]   execute_tag;
    logic [3:0]                  execute_step_m;
    logic [3:0]                  execute_step_n;
    tcu_pkg::fmt_s_e             execute_fmt_s;
    tcu_pkg::fmt_d_e             execute_fmt_d;
    logic [A_LANES*XLEN-1:0]     execute_rs1;
    logic [B_LANES*XLEN-1:0]     execute_rs2;
    logic [C_LANES*XLEN-1:0]     execute_rs3;
    logic                        result_valid;
    logic                        result_ready;
    logic [tcu_pkg::TAG_W-1:0]   result_tag;
    logic [C_LANES*XLEN-1:0]     result_data;

    int                          value_errors;
    int                          unmatched_results;
    int                          pending;
    int                          cycles;
    logic                        random_ready;
    logic [31:0]                 lcg_state;
    logic [31:0]                 ready_state;

    tcu_core #(
        .TC_M (TC_M), .TC_N (TC_N), .TC_K (TC_K),
        .A_SUB_BLOCKS (A_SUB_BLOCKS), .B_SUB_BLOCKS (B_SUB_BLOCKS)
    ) dut (.*);

    tcu_checker #(
        .TC_M (TC_M), .TC_N (TC_N), .TC_K (TC_K),
        .A_SUB_BLOCKS (A_SUB_BLOCKS), .B_SUB_BLOCKS (B_SUB_BLOCKS)
    ) result_checker (.*);

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_random();
        lcg_state = lcg_step(lcg_state);
        return lcg_state;
    endfunction

    task automatic idle(input int n);
        execute_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    // Full 32-bit lanes, so I16 sums overflow and exercise the wrap
    task automatic send_request(input int idx);
        logic [31:0] r;
        r = next_random();
        execute_tag    <= idx[tcu_pkg::TAG_W-1:0];
        execute_step_m <= r[3:0];
        execute_step_n <= r[7:4];
        execute_fmt_s  <= tcu_pkg::fmt_s_e'(r[8]);
        execute_fmt_d  <= tcu_pkg::fmt_d_e'(r[9]);
        for (int l = 0; l < A_LANES; l++) execute_rs1[l*XLEN +: XLEN] <= next_random();
        for (int l = 0; l < B_LANES; l++) execute_rs2[l*XLEN +: XLEN] <= next_random();
        for (int l = 0; l < C_LANES; l++) execute_rs3[l*XLEN +: XLEN] <= next_random();
        execute_valid <= 1'b1;
        @(posedge clk);
        while (!execute_ready) @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the run hung with %0d requests pending",
                     cycles, pending);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Result back-pressure from a separate LCG stream
    always @(posedge clk) begin
        if (random_ready) begin
            ready_state  <= lcg_step(ready_state);
            result_ready <= (ready_state[17:16] != 2'b00);
        end else begin
            result_ready <= 1'b1;
        end
    end

    initial begin
        logic [31:0] r;
        lcg_state      = 32'hb314_6303;
        ready_state    = next_random();
        cycles         = 0;
        random_ready   = 1'b0;
        reset          = 1'b1;
        execute_valid  = 1'b0;
        execute_tag    = '0;
        execute_step_m = '0;
        execute_step_n = '0;
        execute_fmt_s  = tcu_pkg::FMT_S_I8;
        execute_fmt_d  = tcu_pkg::FMT_D_I32;
        execute_rs1    = '0;
        execute_rs2    = '0;
        execute_rs3    = '0;
        result_ready   = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // Lone request, then a back-to-back burst with ready held high
        for (int i = 0; i < NUM_REQ; i++) begin
            if (i == 1) begin
                idle(12);
            end else if (i >= 20) begin
                random_ready <= 1'b1;
                r = next_random();
                if (r[2:0] < 3'd3) idle(int'(r[4:3]) + 1);
            end
            send_request(i);
        end
        execute_valid <= 1'b0;
        @(posedge clk);

        while (pending != 0) @(posedge clk);
        repeat (4) @(posedge clk);

        if (pending != 0) $display("%0d requests were left without a result", pending);
        $display("Errors: %0d value, %0d unmatched results, %0d unanswered requests",
                 value_errors, unmatched_results, pending);
        if (value_errors == 0 && unmatched_results == 0 && pending == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- tb/tcu_checker.sv
// Tensor core result checker
`timescale 1ns/1ps

module tcu_checker #(
    parameter int TC_M         = 2,
    parameter int TC_N         = 2,
    parameter int TC_K         = 4,
    parameter int A_SUB_BLOCKS = 2,
    parameter int B_SUB_BLOCKS = 2
) (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            execute_valid,
    input  logic                                            execute_ready,
    input  logic [tcu_pkg::TAG_W-1:0]                       execute_tag,
    input  logic [3:0]                                      execute_step_m,
    input  logic [3:0]                                      execute_step_n,
    input  tcu_pkg::fmt_s_e                                 execute_fmt_s,
    input  tcu_pkg::fmt_d_e                                 execute_fmt_d,
    input  logic [A_SUB_BLOCKS*TC_M*TC_K*tcu_pkg::XLEN-1:0] execute_rs1,
    input  logic [B_SUB_BLOCKS*TC_N*TC_K*tcu_pkg::XLEN-1:0] execute_rs2,
    input  logic [TC_M*TC_N*tcu_pkg::XLEN-1:0]              execute_rs3,
    input  logic                                            result_valid,
    input  logic                                            result_ready,
    input  logic [tcu_pkg::TAG_W-1:0]                       result_tag,
    input  logic [TC_M*TC_N*tcu_pkg::XLEN-1:0]              result_data,
    output int                                              value_errors,
    output int                                              unmatched_results,
    output int                                              pending
);
    localparam int XLEN         = tcu_pkg::XLEN;
    localparam int D_W          = TC_M * TC_N * XLEN;
    localparam int PIPE_LATENCY = 5;
    localparam int QUEUE_DEPTH  = 8;

    logic [D_W-1:0]            exp_data_q [$];
    logic [tcu_pkg::TAG_W-1:0] exp_tag_q [$];
    int                        age_q [$];
    logic                      enable;
    logic                      exp_valid;
    logic                      exp_ready;

    function automatic logic signed [XLEN-1:0] read_elem(
        input logic [XLEN-1:0] lane,
        input tcu_pkg::fmt_s_e fs
    );
        logic signed [7:0]  e8;
        logic signed [15:0] e16;
        e8  = lane[7:0];
        e16 = lane[15:0];
        if (fs == tcu_pkg::FMT_S_I8) begin
            return XLEN'(e8);
        end
        return XLEN'(e16);
    endfunction

    // D = A*B + C for the sub-blocks that the steps select
    function automatic logic [D_W-1:0] ref_tile(
        input logic [A_SUB_BLOCKS*TC_M*TC_K*XLEN-1:0] rs1,
        input logic [B_SUB_BLOCKS*TC_N*TC_K*XLEN-1:0] rs2,
        input logic [D_W-1:0]                         rs3,
        input logic [3:0]                             sm,
        input logic [3:0]                             sn,
        input tcu_pkg::fmt_s_e                        fs,
        input tcu_pkg::fmt_d_e                        fd
    );
        logic [D_W-1:0]         d;
        logic signed [XLEN-1:0] sum;
        logic signed [15:0]     low;
        int                     a_base;
        int                     b_base;
        d      = '0;
        a_base = (int'(sm) % A_SUB_BLOCKS) * TC_M * TC_K;
        b_base = (int'(sn) % B_SUB_BLOCKS) * TC_N * TC_K;
        for (int i = 0; i < TC_M; i++) begin
            for (int j = 0; j < TC_N; j++) begin
                sum = rs3[(i * TC_N + j) * XLEN +: XLEN];
                for (int k = 0; k < TC_K; k++) begin
                    sum = sum + read_elem(rs1[(a_base + i * TC_K + k) * XLEN +: XLEN], fs)
                              * read_elem(rs2[(b_base + j * TC_K + k) * XLEN +: XLEN], fs);
                end
                low = sum[15:0];
                if (fd == tcu_pkg::FMT_D_I16) begin
                    d[(i * TC_N + j) * XLEN +: XLEN] = XLEN'(low);
                end else begin
                    d[(i * TC_N + j) * XLEN +: XLEN] = sum;
                end
            end
        end
        return d;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            exp_data_q.delete();
            exp_tag_q.delete();
            age_q.delete();
            value_errors      = 0;
            unmatched_results = 0;
        end else begin
            enable    = !result_valid || result_ready;
            // Head is due once it has seen PIPE_LATENCY enabled edges
            exp_valid = (age_q.size() > 0) && (age_q[0] >= PIPE_LATENCY);
            exp_ready = enable && (exp_data_q.size() < QUEUE_DEPTH);
            if (result_valid !== exp_valid) begin
                $display("[ERROR] %0t: result_valid is %b, expected %b",
                         $time, result_valid, exp_valid);
                value_errors++;
            end
            if (execute_ready !== exp_ready) begin
                $display("[ERROR] %0t: execute_ready is %b, expected %b",
                         $time, execute_ready, exp_ready);
                value_errors++;
            end

            if (result_valid && result_ready) begin
                if (exp_data_q.size() == 0) begin
                    $display("A result came out at %0t with no request waiting for it", $time);
                    unmatched_results++;
                end else begin
                    if (result_data !== exp_data_q[0]) begin
                        $display("[ERROR] %0t: tag %h data %h, expected %h",
                                 $time, exp_tag_q[0], result_data, exp_data_q[0]);
                        value_errors++;
                    end
                    if (result_tag !== exp_tag_q[0]) begin
                        $display("[ERROR] %0t: result_tag %h, expected %h",
                                 $time, result_tag, exp_tag_q[0]);
                        value_errors++;
                    end
                    void'(exp_data_q.pop_front());
                    void'(exp_tag_q.pop_front());
                    void'(age_q.pop_front());
                end
            end

            if (enable) begin
                for (int i = 0; i < age_q.size(); i++) begin
                    age_q[i] = age_q[i] + 1;
                end
            end

            if (execute_valid && execute_ready) begin
                exp_data_q.push_back(ref_tile(execute_rs1, execute_rs2, execute_rs3,
                                              execute_step_m, execute_step_n,
                                              execute_fmt_s, execute_fmt_d));
                exp_tag_q.push_back(execute_tag);
                // The accept edge loads the input buffer, the first enabled edge
                age_q.push_back(1);
            end
        end
        pending = exp_data_q.size();
    end

endmodule

//--- src/tcu_core.sv
// Integer tensor core tile
`timescale 1ns/1ps

module tcu_core #(
    parameter int TC_M         = 2,
    parameter int TC_N         = 2,
    parameter int TC_K         = 4,
    parameter int A_SUB_BLOCKS = 2,
    parameter int B_SUB_BLOCKS = 2
) (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             execute_valid,
    output logic                                             execute_ready,
    input  logic [tcu_pkg::TAG_W-1:0]                        execute_tag,
    input  logic [3:0]                                       execute_step_m,
    input  logic [3:0]                                       execute_step_n,
    input  tcu_pkg::fmt_s_e                                  execute_fmt_s,
    input  tcu_pkg::fmt_d_e                                  execute_fmt_d,
    input  logic [A_SUB_BLOCKS*TC_M*TC_K*tcu_pkg::XLEN-1:0]  execute_rs1,
    input  logic [B_SUB_BLOCKS*TC_N*TC_K*tcu_pkg::XLEN-1:0]  execute_rs2,
    input  logic [TC_M*TC_N*tcu_pkg::XLEN-1:0]               execute_rs3,
    output logic                                             result_valid,
    input  logic                                             result_ready,
    output logic [tcu_pkg::TAG_W-1:0]                        result_tag,
    output logic [TC_M*TC_N*tcu_pkg::XLEN-1:0]               result_data
);
    localparam int XLEN         = tcu_pkg::XLEN;
    localparam int FEDP_LATENCY = $clog2(TC_K) + 2;
    localparam int PIPE_LATENCY = FEDP_LATENCY + 1;
    localparam int MDATA_DEPTH  = 1 << $clog2(PIPE_LATENCY);
    localparam int A_BS         = TC_M * TC_K;
    localparam int B_BS         = TC_N * TC_K;
    localparam int A_IDX_W      = $clog2(A_SUB_BLOCKS * A_BS);
    localparam int B_IDX_W      = $clog2(B_SUB_BLOCKS * B_BS);

    logic                      execute_fire;
    logic                      result_fire;
    logic                      fedp_enable;
    logic                      mdata_full;
    logic [PIPE_LATENCY-1:0]   delay_pipe;
    logic [A_IDX_W-1:0]        a_off;
    logic [B_IDX_W-1:0]        b_off;

    // Input buffer
    logic [TC_K*XLEN-1:0]      a_rows_r [TC_M];
    logic [TC_K*XLEN-1:0]      b_cols_r [TC_N];
    logic [TC_M*TC_N*XLEN-1:0] c_tile_r;
    tcu_pkg::fmt_s_e           fmt_s_r;
    tcu_pkg::fmt_d_e           fmt_d_r;

    assign execute_fire  = execute_valid && execute_ready;
    assign result_fire   = result_valid && result_ready;
    assign fedp_enable   = !result_valid || result_ready;
    assign execute_ready = !mdata_full && fedp_enable;

    // Valid slot tracker, one bit per pipeline stage
    always_ff @(posedge clk) begin
        if (reset) begin
            delay_pipe <= '0;
        end else begin
            if (fedp_enable) begin
                delay_pipe <= delay_pipe >> 1;
            end
            if (execute_fire) begin
                delay_pipe[PIPE_LATENCY-1] <= 1'b1;
            end
        end
    end

    assign result_valid = delay_pipe[0];

    tcu_meta_fifo #(
        .DATAW (tcu_pkg::TAG_W),
        .DEPTH (MDATA_DEPTH)
    ) mdata_queue (
        .clk      (clk),
        .reset    (reset),
        .push     (execute_fire),
        .pop      (result_fire),
        .data_in  (execute_tag),
        .data_out (result_tag),
        .full     (mdata_full)
    );

    // Sub-block lane offsets, step wraps on the block count
    assign a_off = A_IDX_W'((execute_step_m % A_SUB_BLOCKS) * A_BS);
    assign b_off = B_IDX_W'((execute_step_n % B_SUB_BLOCKS) * B_BS);

    always_ff @(posedge clk) begin
        if (fedp_enable) begin
            for (int i = 0; i < TC_M; i++) begin
                a_rows_r[i] <= execute_rs1[(a_off + i * TC_K) * XLEN +: TC_K * XLEN];
            end
            for (int j = 0; j < TC_N; j++) begin
                b_cols_r[j] <= execute_rs2[(b_off + j * TC_K) * XLEN +: TC_K * XLEN];
            end
            c_tile_r <= execute_rs3;
            fmt_s_r  <= execute_fmt_s;
            fmt_d_r  <= execute_fmt_d;
        end
    end

    // One FEDP per output element
    for (genvar i = 0; i < TC_M; i++) begin : g_i
        for (genvar j = 0; j < TC_N; j++) begin : g_j
            tcu_fedp #(
                .N (TC_K)
            ) fedp (
                .clk    (clk),
                .reset  (reset),
                .enable (fedp_enable),
                .fmt_s  (fmt_s_r),
                .fmt_d  (fmt_d_r),
                .a_row  (a_rows_r[i]),
                .b_col  (b_cols_r[j]),
                .c_val  (c_tile_r[(i * TC_N + j) * XLEN +: XLEN]),
                .d_val  (result_data[(i * TC_N + j) * XLEN +: XLEN])
            );
        end
    end

    // Every valid result must have its tag waiting in the queue
    assert property (@(posedge clk) disable iff (reset)
        result_valid |-> mdata_queue.count != '0)
        else $error("tcu_core: result without a queued tag");

    assert property (@(posedge clk) disable iff (reset)
        result_valid && !result_ready |=>
            result_valid && $stable(result_data) && $stable(result_tag))
        else $error("tcu_core: result changed under back-pressure");

endmodule

//--- src/tcu_fedp.sv
// Fused integer dot-product pipeline
`timescale 1ns/1ps

module tcu_fedp #(
    parameter int N = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       enable,
    input  tcu_pkg::fmt_s_e            fmt_s,
    input  tcu_pkg::fmt_d_e            fmt_d,
    input  logic [N*tcu_pkg::XLEN-1:0] a_row,
    input  logic [N*tcu_pkg::XLEN-1:0] b_col,
    input  logic [tcu_pkg::XLEN-1:0]   c_val,
    output logic [tcu_pkg::XLEN-1:0]   d_val
);
    localparam int XLEN   = tcu_pkg::XLEN;
    localparam int LEVELS = $clog2(N);

    // Adder tree in heap order
    // Leaves hold the products at N-1 .. 2N-2, node 0 is the root
    logic [XLEN-1:0] node [2*N-1];

    // C and destination format travel alongside the tree
    logic [XLEN-1:0]  c_pipe [LEVELS+1];
    tcu_pkg::fmt_d_e  fmt_d_pipe [LEVELS+1];

    logic [XLEN-1:0] acc;

    function automatic logic [XLEN-1:0] sext(
        input logic [XLEN-1:0] x,
        input tcu_pkg::fmt_s_e f
    );
        logic [XLEN-1:0] r;
        if (f == tcu_pkg::FMT_S_I8) begin
            r = {{(XLEN-8){x[7]}}, x[7:0]};
        end else begin
            r = {{(XLEN-16){x[15]}}, x[15:0]};
        end
        return r;
    endfunction

    assign acc = node[0] + c_pipe[LEVELS];

    always_ff @(posedge clk) begin
        if (enable) begin
            // Stage 1, element products
            // Low 32 bits of the extended product equal the signed product
            for (int k = 0; k < N; k++) begin
                logic [XLEN-1:0] a_ext;
                logic [XLEN-1:0] b_ext;
                a_ext = sext(a_row[k*XLEN +: XLEN], fmt_s);
                b_ext = sext(b_col[k*XLEN +: XLEN], fmt_s);
                node[N-1+k] <= a_ext * b_ext;
            end

            // One tree level per cycle
            for (int k = 0; k < N - 1; k++) begin
                node[k] <= node[2*k+1] + node[2*k+2];
            end

            c_pipe[0]     <= c_val;
            fmt_d_pipe[0] <= fmt_d;
            for (int s = 1; s <= LEVELS; s++) begin
                c_pipe[s]     <= c_pipe[s-1];
                fmt_d_pipe[s] <= fmt_d_pipe[s-1];
            end

            // Final stage, accumulate and apply destination format
            if (fmt_d_pipe[LEVELS] == tcu_pkg::FMT_D_I16) begin
                d_val <= {{(XLEN-16){acc[15]}}, acc[15:0]};
            end else begin
                d_val <= acc;
            end
        end
    end

    // Tree depth assumes a full binary tree
    assert property (@(posedge clk) disable iff (reset) (N & (N - 1)) == 0)
        else $error("tcu_fedp: N must be a power of two");

endmodule

//--- src/tcu_meta_fifo.sv
// Request tag queue
`timescale 1ns/1ps

module tcu_meta_fifo #(
    parameter int DATAW = 8,
    parameter int DEPTH = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  logic             pop,
    input  logic [DATAW-1:0] data_in,
    output logic [DATAW-1:0] data_out,
    output logic             full
);
    localparam int PTR_W = $clog2(DEPTH);

    logic [DATAW-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr_next;
    logic [PTR_W:0]   count;

    assign rd_ptr_next = rd_ptr + 1'b1;
    assign full        = (count == (PTR_W + 1)'(DEPTH));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr_next;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head register, loaded from the input when the queue is or becomes
    // a single fresh entry, otherwise from the next slot on a pop
    always_ff @(posedge clk) begin
        if (push && (count == '0 || (pop && count == (PTR_W + 1)'(1)))) begin
            data_out <= data_in;
        end else if (pop && count > (PTR_W + 1)'(1)) begin
            data_out <= mem[rd_ptr_next];
        end
    end

    assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("tcu_meta_fifo: push while full");

    assert property (@(posedge clk) disable iff (reset) pop |-> count != '0)
        else $error("tcu_meta_fifo: pop while empty");

endmodule

//--- src/tcu_pkg.sv
// Tensor core shared definitions
package tcu_pkg;

    // Lane width of operands and results
    localparam int XLEN = 32;

    // Request tag carried beside the datapath
    localparam int TAG_W = 8;

    // Source element format, taken from the low bits of each lane
    typedef enum logic [0:0] {
        FMT_S_I8  = 1'b0,
        FMT_S_I16 = 1'b1
    } fmt_s_e;

    // Destination format
    // I16 wraps the sum to 16 bits and sign-extends it back to a full lane
    typedef enum logic [0:0] {
        FMT_D_I32 = 1'b0,
        FMT_D_I16 = 1'b1
    } fmt_d_e;

endpackage
